//--- Makefile
VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert -Wall
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- project.f
src/corePkg.sv
src/pipeEnable.sv
src/instrDecode.sv
src/regFile.sv
src/execUnit.sv
src/branchUnit.sv
src/coreTop.sv
tests/coreTop_asserts.sv
tests/coreTb.sv

//--- src/branchUnit.sv
`default_nettype none
`timescale 1ns/100ps

module branchUnit #(
  parameter int IW = 32 // Instruction address width
) (
  input  logic                   sys_clk_i,
  input  logic                   rst_i,
  input  logic                   cpuEnable_i,
  input  logic                   hold_i,
  input  corePkg::decodedInstr_t instr_i,
  input  logic [31:0]            raData_i,
  output logic [31:0]            icacheAddr_o,
  output logic                   squash_o
);

  logic [IW-1:0] fetchPc; // Next address to fetch when no branch is taken
  logic [IW-1:0] exPc;    // Address of the instruction in execute
  logic [IW-1:0] target;
  logic [IW-1:0] nextPc;
  logic          raZero;
  logic          taken;

  assign raZero = (raData_i == '0);

  always_comb begin
    case (instr_i.branchKind)
      corePkg::BrAlways:  taken = instr_i.valid;
      corePkg::BrZero:    taken = instr_i.valid && raZero;
      corePkg::BrNonzero: taken = instr_i.valid && !raZero;
      default:            taken = 1'b0;
    endcase
  end

  assign target   = exPc + instr_i.imm[IW-1:0];
  assign nextPc   = taken ? {target[IW-1:2], 2'b00} : fetchPc;
  assign squash_o = taken; // Kills the word arriving in decode

  // Target goes out in the same cycle, so a taken branch costs one bubble
  assign icacheAddr_o = 32'(nextPc);

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      fetchPc <= '0;
      exPc    <= '0;
    end else if (cpuEnable_i && !hold_i) begin
      fetchPc <= nextPc + IW'(4);
      exPc    <= fetchPc - IW'(4); // Word now entering decode was fetched last edge
    end
  end

endmodule

`default_nettype wire

//--- src/corePkg.sv
`default_nettype none

package corePkg;

  // Major opcodes in MicroBlaze encoding, bits 31:26 of the instruction
  localparam logic [5:0] OpcAdd   = 6'h00;
  localparam logic [5:0] OpcRsub  = 6'h01;
  localparam logic [5:0] OpcAddi  = 6'h08;
  localparam logic [5:0] OpcRsubi = 6'h09;
  localparam logic [5:0] OpcBs    = 6'h11; // Barrel shift, amount from rb
  localparam logic [5:0] OpcBsi   = 6'h19; // Barrel shift, amount from imm
  localparam logic [5:0] OpcOr    = 6'h20;
  localparam logic [5:0] OpcAnd   = 6'h21;
  localparam logic [5:0] OpcXor   = 6'h22;
  localparam logic [5:0] OpcOri   = 6'h28;
  localparam logic [5:0] OpcAndi  = 6'h29;
  localparam logic [5:0] OpcXori  = 6'h2A;
  localparam logic [5:0] OpcBri   = 6'h2E; // Unconditional relative branch
  localparam logic [5:0] OpcBcci  = 6'h2F; // Conditional branch, test in rd field
  localparam logic [5:0] OpcLwi   = 6'h3A;
  localparam logic [5:0] OpcSwi   = 6'h3E;

  // Condition codes carried in the rd field of OpcBcci
  localparam logic [4:0] CondEq = 5'd0;
  localparam logic [4:0] CondNe = 5'd1;

  typedef enum logic [2:0] {
    AluAdd,
    AluRsub,
    AluAnd,
    AluOr,
    AluXor,
    AluSll,
    AluSrl,
    AluPass
  } aluOp_e;

  typedef enum logic [1:0] {
    BrNone,
    BrAlways,
    BrZero,    // Taken when ra is zero
    BrNonzero
  } branchKind_e;

  typedef struct packed {
    aluOp_e      aluOp;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;      // Holds the store data register for stores
    logic [31:0] imm;     // Already sign extended
    logic        useImm;
    logic        regWrite;
    logic        isLoad;
    logic        isStore;
    branchKind_e branchKind;
    logic        valid;
  } decodedInstr_t;

  typedef struct packed {
    logic        we;
    logic [4:0]  addr;
    logic [31:0] data;
  } wbReq_t;

endpackage

`default_nettype wire

//--- src/coreTop.sv
`default_nettype none
`timescale 1ns/100ps

module coreTop #(
  parameter int IW  = 32, // Instruction address width
  parameter int BSF = 1   // Barrel shifter option
) (
  input  logic        sys_clk_i,
  input  logic        rst_i,
  output logic [31:0] icacheAddr_o,
  output logic        icacheEn_o,
  input  logic [31:0] icacheData_i,
  input  logic        icacheBusy_i,
  output logic [31:0] dcacheAddr_o,
  output logic [31:0] dcacheWrData_o,
  output logic        dcacheWe_o,
  output logic        dcacheEn_o,
  input  logic [31:0] dcacheRdData_i,
  input  logic        dcacheBusy_i
);

  corePkg::decodedInstr_t decInstr;
  corePkg::wbReq_t        wbReq;
  logic                   cpuEnable;
  logic                   loadBubble;
  logic                   squash;
  logic [31:0]            raData;
  logic [31:0]            rbData;

  pipeEnable u_enable (
    .sys_clk_i    (sys_clk_i),
    .rst_i        (rst_i),
    .icacheBusy_i (icacheBusy_i),
    .dcacheBusy_i (dcacheBusy_i),
    .exInstr_i    (decInstr),
    .cpuEnable_o  (cpuEnable),
    .icacheEn_o   (icacheEn_o),
    .dcacheEn_o   (dcacheEn_o),
    .loadBubble_o (loadBubble)
  );

  instrDecode u_decode (
    .sys_clk_i    (sys_clk_i),
    .rst_i        (rst_i),
    .cpuEnable_i  (cpuEnable),
    .hold_i       (loadBubble),
    .squash_i     (squash),
    .icacheData_i (icacheData_i),
    .decInstr_o   (decInstr)
  );

  regFile u_regFile (
    .sys_clk_i (sys_clk_i),
    .raAddr_i  (decInstr.ra),
    .rbAddr_i  (decInstr.rb),
    .wb_i      (wbReq),
    .raData_o  (raData),
    .rbData_o  (rbData)
  );

  execUnit #(.BSF(BSF)) u_exec (
    .sys_clk_i      (sys_clk_i),
    .rst_i          (rst_i),
    .cpuEnable_i    (cpuEnable),
    .instr_i        (decInstr),
    .raData_i       (raData),
    .rbData_i       (rbData),
    .dcacheRdData_i (dcacheRdData_i),
    .dcacheAddr_o   (dcacheAddr_o),
    .dcacheWrData_o (dcacheWrData_o),
    .dcacheWe_o     (dcacheWe_o),
    .wb_o           (wbReq)
  );

  branchUnit #(.IW(IW)) u_branch (
    .sys_clk_i    (sys_clk_i),
    .rst_i        (rst_i),
    .cpuEnable_i  (cpuEnable),
    .hold_i       (loadBubble),
    .instr_i      (decInstr),
    .raData_i     (raData),
    .icacheAddr_o (icacheAddr_o),
    .squash_o     (squash)
  );

endmodule

`default_nettype wire

//--- src/execUnit.sv
`default_nettype none
`timescale 1ns/100ps

module execUnit #(
  parameter int BSF = 1 // Barrel shifter present
) (
  input  logic                   sys_clk_i,
  input  logic                   rst_i,
  input  logic                   cpuEnable_i,
  input  corePkg::decodedInstr_t instr_i,
  input  logic [31:0]            raData_i,
  input  logic [31:0]            rbData_i,
  input  logic [31:0]            dcacheRdData_i,
  output logic [31:0]            dcacheAddr_o,
  output logic [31:0]            dcacheWrData_o,
  output logic                   dcacheWe_o,
  output corePkg::wbReq_t        wb_o
);

  logic [31:0] opB;
  logic [31:0] aluResult;
  logic [31:0] memAddr;
  logic        isShift;
  logic        memOp;
  logic        resultWe;
  logic        loadPend;
  logic [4:0]  loadRd;
  logic        wbWe;
  logic [4:0]  wbAddr;
  logic [31:0] wbData;

  assign opB     = instr_i.useImm ? instr_i.imm : rbData_i;
  assign isShift = instr_i.aluOp inside {corePkg::AluSll, corePkg::AluSrl};

  always_comb begin
    case (instr_i.aluOp)
      corePkg::AluAdd:  aluResult = raData_i + opB;
      corePkg::AluRsub: aluResult = opB - raData_i; // Reverse subtract
      corePkg::AluAnd:  aluResult = raData_i & opB;
      corePkg::AluOr:   aluResult = raData_i | opB;
      corePkg::AluXor:  aluResult = raData_i ^ opB;
      corePkg::AluSll:  aluResult = raData_i << opB[4:0];
      corePkg::AluSrl:  aluResult = raData_i >> opB[4:0];
      corePkg::AluPass: aluResult = opB;
    endcase
  end

  // Without the barrel shifter the shifts retire as no-ops
  assign resultWe = instr_i.valid && instr_i.regWrite && !(isShift && BSF == 0);

  assign memOp          = instr_i.valid && (instr_i.isLoad || instr_i.isStore);
  assign memAddr        = raData_i + opB;
  assign dcacheAddr_o   = memOp ? {memAddr[31:2], 2'b00} : '0; // Word aligned
  assign dcacheWrData_o = (memOp && instr_i.isStore) ? rbData_i : '0;
  assign dcacheWe_o     = instr_i.valid && instr_i.isStore;

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      loadPend <= 1'b0;
      wbWe     <= 1'b0;
    end else if (cpuEnable_i) begin
      loadPend <= instr_i.valid && instr_i.isLoad;
      wbWe     <= loadPend || resultWe; // Returning load data takes the write slot
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_i) begin
      loadRd <= instr_i.rd;
      wbAddr <= loadPend ? loadRd : instr_i.rd;
      wbData <= loadPend ? dcacheRdData_i : aluResult;
    end
  end

  assign wb_o = '{we: wbWe, addr: wbAddr, data: wbData};

endmodule

`default_nettype wire

//--- src/instrDecode.sv
`default_nettype none
`timescale 1ns/100ps

module instrDecode (
  input  logic                   sys_clk_i,
  input  logic                   rst_i,
  input  logic                   cpuEnable_i,
  input  logic                   hold_i,
  input  logic                   squash_i,
  input  logic [31:0]            icacheData_i,
  output corePkg::decodedInstr_t decInstr_o
);

  logic [31:0] instrWord;
  logic        wordValid;
  logic        fetchPending; // An address was accepted, so the cache has a word for us
  logic [5:0]  opc;

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      wordValid    <= 1'b0;
      fetchPending <= 1'b0;
    end else if (cpuEnable_i && !hold_i) begin
      wordValid    <= fetchPending && !squash_i; // Drop the word behind a taken branch
      fetchPending <= 1'b1;
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_i && !hold_i) begin
      instrWord <= icacheData_i;
    end
  end

  assign opc = instrWord[31:26];

  always_comb begin
    decInstr_o            = '0;
    decInstr_o.rd         = instrWord[25:21];
    decInstr_o.ra         = instrWord[20:16];
    decInstr_o.rb         = instrWord[15:11];
    decInstr_o.imm        = {{16{instrWord[15]}}, instrWord[15:0]};
    decInstr_o.useImm     = opc[3]; // Immediate flag of the major opcode
    decInstr_o.valid      = wordValid && !hold_i;
    decInstr_o.aluOp      = corePkg::AluPass;
    decInstr_o.branchKind = corePkg::BrNone;
    case (opc)
      corePkg::OpcAdd, corePkg::OpcAddi: begin
        decInstr_o.aluOp    = corePkg::AluAdd;
        decInstr_o.regWrite = 1'b1;
      end
      corePkg::OpcRsub, corePkg::OpcRsubi: begin
        decInstr_o.aluOp    = corePkg::AluRsub;
        decInstr_o.regWrite = 1'b1;
      end
      corePkg::OpcAnd, corePkg::OpcAndi: begin
        decInstr_o.aluOp    = corePkg::AluAnd;
        decInstr_o.regWrite = 1'b1;
      end
      corePkg::OpcOr, corePkg::OpcOri: begin
        decInstr_o.aluOp    = corePkg::AluOr;
        decInstr_o.regWrite = 1'b1;
      end
      corePkg::OpcXor, corePkg::OpcXori: begin
        decInstr_o.aluOp    = corePkg::AluXor;
        decInstr_o.regWrite = 1'b1;
      end
      corePkg::OpcBs, corePkg::OpcBsi: begin
        // Bit 10 selects a left shift
        decInstr_o.aluOp    = instrWord[10] ? corePkg::AluSll : corePkg::AluSrl;
        decInstr_o.regWrite = 1'b1;
      end
      corePkg::OpcLwi: decInstr_o.isLoad = 1'b1;
      corePkg::OpcSwi: begin
        decInstr_o.isStore = 1'b1;
        decInstr_o.rb      = instrWord[25:21]; // Store data comes through read port B
      end
      corePkg::OpcBri: decInstr_o.branchKind = corePkg::BrAlways;
      corePkg::OpcBcci: begin
        if (instrWord[25:21] == corePkg::CondEq) begin
          decInstr_o.branchKind = corePkg::BrZero;
        end else if (instrWord[25:21] == corePkg::CondNe) begin
          decInstr_o.branchKind = corePkg::BrNonzero;
        end
      end
      default: ; // Unsupported opcodes run as no-ops
    endcase
  end

endmodule

`default_nettype wire

//--- src/pipeEnable.sv
`default_nettype none
`timescale 1ns/100ps

module pipeEnable (
  input  logic                   sys_clk_i,
  input  logic                   rst_i,
  input  logic                   icacheBusy_i,
  input  logic                   dcacheBusy_i,
  input  corePkg::decodedInstr_t exInstr_i,
  output logic                   cpuEnable_o,
  output logic                   icacheEn_o,
  output logic                   dcacheEn_o,
  output logic                   loadBubble_o
);

  logic loadPend; // Load data still on its way back

  // Either cache being busy freezes every stage
  assign cpuEnable_o = !(icacheBusy_i || dcacheBusy_i);

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      loadPend <= 1'b0;
    end else if (cpuEnable_o) begin
      loadPend <= exInstr_i.valid && exInstr_i.isLoad;
    end
  end

  assign loadBubble_o = loadPend;

  // The enables depend on pipeline state only, so they hold through a stall.
  // During the bubble the icache keeps the word it already fetched.
  assign icacheEn_o = !loadPend;
  assign dcacheEn_o = exInstr_i.valid && (exInstr_i.isLoad || exInstr_i.isStore);

endmodule

`default_nettype wire

//--- src/regFile.sv
`default_nettype none
`timescale 1ns/100ps

module regFile (
  input  logic            sys_clk_i,
  input  logic [4:0]      raAddr_i,
  input  logic [4:0]      rbAddr_i,
  input  corePkg::wbReq_t wb_i,
  output logic [31:0]     raData_o,
  output logic [31:0]     rbData_o
);

  logic [31:0] regs [1:31]; // r0 has no storage

  always_ff @(posedge sys_clk_i) begin
    if (wb_i.we && wb_i.addr != 5'd0) begin
      regs[wb_i.addr] <= wb_i.data;
    end
  end

  // Pending writeback wins over the array so back-to-back use needs no stall
  function automatic logic [31:0] readReg(input logic [4:0] addr);
    logic [31:0] value;
    if (addr == 5'd0) begin
      value = '0;
    end else if (wb_i.we && wb_i.addr == addr) begin
      value = wb_i.data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_comb begin
    raData_o = readReg(raAddr_i);
  end

  always_comb begin
    rbData_o = readReg(rbAddr_i);
  end

endmodule

`default_nettype wire

//--- tests/coreTb.sv
`default_nettype none
`timescale 1ns/100ps

module coreTb;

  localparam int          ProgWords     = 256;
  localparam int          BodyEnd       = ProgWords - 8; // Store sweep starts here
  localparam int          DataWords     = 64;
  localparam int          TimeoutCycles = ProgWords * 3 * 2;
  localparam logic [31:0] Seed          = 32'hffb8cf20;

  logic        clk;
  logic        rst;
  logic [31:0] icacheAddr;
  logic        icacheEn;
  logic [31:0] icacheData;
  logic        icacheBusy;
  logic [31:0] dcacheAddr;
  logic [31:0] dcacheWrData;
  logic        dcacheWe;
  logic        dcacheEn;
  logic [31:0] dcacheRdData;
  logic        dcacheBusy;

  logic [31:0] imem [ProgWords];
  logic [31:0] dmem [DataWords]; // Data cache contents seen by the DUT
  logic [31:0] expAddr [$];      // Store list from the model in program order
  logic [31:0] expData [$];
  int          storeCnt;
  int          errCnt;
  int          cycleCnt;

  coreTop #(.IW(32), .BSF(1)) u_dut (
    .sys_clk_i      (clk),
    .rst_i          (rst),
    .icacheAddr_o   (icacheAddr),
    .icacheEn_o     (icacheEn),
    .icacheData_i   (icacheData),
    .icacheBusy_i   (icacheBusy),
    .dcacheAddr_o   (dcacheAddr),
    .dcacheWrData_o (dcacheWrData),
    .dcacheWe_o     (dcacheWe),
    .dcacheEn_o     (dcacheEn),
    .dcacheRdData_i (dcacheRdData),
    .dcacheBusy_i   (dcacheBusy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] fillWord(input int idx);
    return 32'h9E3779B9 * 32'(idx + 1);
  endfunction

  function automatic logic [31:0] regFormWord(input logic [5:0] opc, input logic [4:0] rd,
                                              input logic [4:0] ra, input logic [4:0] rb,
                                              input logic leftBit);
    return {opc, rd, ra, rb, leftBit, 10'd0};
  endfunction

  function automatic logic [31:0] immFormWord(input logic [5:0] opc, input logic [4:0] rd,
                                              input logic [4:0] ra, input logic [15:0] imm);
    return {opc, rd, ra, imm};
  endfunction

  // Byte offset inside the data region with random low bits
  function automatic logic [15:0] dataOffset();
    return 16'($urandom_range(4 * DataWords - 1, 0));
  endfunction

  function automatic logic [5:0] aluOpcode(input int sel, input logic useImm);
    case (sel)
      0:       return useImm ? corePkg::OpcAddi : corePkg::OpcAdd;
      1:       return useImm ? corePkg::OpcRsubi : corePkg::OpcRsub;
      2:       return useImm ? corePkg::OpcAndi : corePkg::OpcAnd;
      3:       return useImm ? corePkg::OpcOri : corePkg::OpcOr;
      default: return useImm ? corePkg::OpcXori : corePkg::OpcXor;
    endcase
  endfunction

  // Register init, random body, store sweep of r1-r7, then branch to self
  task automatic buildProgram();
    logic [4:0] rd;
    logic [4:0] ra;
    logic [4:0] rb;
    int         skip;
    for (int i = 0; i < ProgWords; i++) begin
      rd = 5'($urandom_range(7, 0));
      ra = 5'($urandom_range(7, 0));
      rb = 5'($urandom_range(7, 0));
      skip = int'($urandom_range(4, 0));
      if (i + 1 + skip > BodyEnd) skip = BodyEnd - i - 1; // Stay ahead of the sweep
      if (i < 7) begin
        imem[i] = immFormWord(corePkg::OpcAddi, 5'(i + 1), 5'd0, 16'($urandom));
      end else if (i == ProgWords - 1) begin
        imem[i] = immFormWord(corePkg::OpcBri, 5'd0, 5'd0, 16'd0);
      end else if (i >= BodyEnd) begin
        imem[i] = immFormWord(corePkg::OpcSwi, 5'(i - BodyEnd + 1), 5'd0, 16'(4 * (i - BodyEnd)));
      end else begin
        case ($urandom_range(9, 0))
          0, 1: imem[i] = regFormWord(aluOpcode(int'($urandom_range(4, 0)), 1'b0), rd, ra, rb, 1'b0);
          2:    imem[i] = immFormWord(aluOpcode(int'($urandom_range(4, 0)), 1'b1), rd, ra,
                                      16'($urandom));
          3:    imem[i] = regFormWord(corePkg::OpcBs, rd, ra, rb, 1'($urandom_range(1, 0)));
          4:    imem[i] = immFormWord(corePkg::OpcBsi, rd, ra,
                                      {5'd0, 1'($urandom_range(1, 0)), 5'd0, 5'($urandom)});
          5:    imem[i] = immFormWord(corePkg::OpcLwi, rd, 5'd0, dataOffset());
          6:    imem[i] = immFormWord(corePkg::OpcSwi, rd, 5'd0, dataOffset());
          7:    imem[i] = immFormWord(corePkg::OpcBri, 5'd0, 5'd0, 16'(4 * (skip + 1)));
          default: imem[i] = immFormWord(corePkg::OpcBcci, 5'($urandom_range(1, 0)), ra,
                                         16'(4 * (skip + 1)));
        endcase
      end
    end
  endtask

  // Instruction-level model stepping one instruction at a time
  task automatic runModel();
    logic [31:0] regs [32];
    logic [31:0] mem [DataWords];
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] pc;
    logic [5:0]  opc;
    logic [4:0]  rd;
    logic        writes;
    logic        done;
    int          steps;
    for (int k = 0; k < 32; k++) regs[k] = '0;
    for (int k = 0; k < DataWords; k++) mem[k] = fillWord(k);
    pc = '0;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 4 * ProgWords) begin
      w      = imem[pc[9:2]];
      opc    = w[31:26];
      rd     = w[25:21];
      a      = regs[w[20:16]];
      b      = opc[3] ? {{16{w[15]}}, w[15:0]} : regs[w[15:11]];
      res    = a + b; // Also the data address
      writes = 1'b1;
      case (opc)
        corePkg::OpcAdd, corePkg::OpcAddi:   res = a + b;
        corePkg::OpcRsub, corePkg::OpcRsubi: res = b - a;
        corePkg::OpcAnd, corePkg::OpcAndi:   res = a & b;
        corePkg::OpcOr, corePkg::OpcOri:     res = a | b;
        corePkg::OpcXor, corePkg::OpcXori:   res = a ^ b;
        corePkg::OpcBs, corePkg::OpcBsi:     res = w[10] ? a << b[4:0] : a >> b[4:0];
        corePkg::OpcLwi:                     res = mem[res[7:2]];
        corePkg::OpcSwi: begin
          expAddr.push_back({res[31:2], 2'b00});
          expData.push_back(regs[rd]);
          mem[res[7:2]] = regs[rd];
          writes = 1'b0;
        end
        corePkg::OpcBri: begin
          done = (w[15:0] == 16'd0);
          pc = pc + b - 32'd4;
          writes = 1'b0;
        end
        corePkg::OpcBcci: begin
          if ((rd == corePkg::CondEq && a == '0) || (rd == corePkg::CondNe && a != '0)) begin
            pc = pc + b - 32'd4;
          end
          writes = 1'b0;
        end
        default: writes = 1'b0;
      endcase
      if (writes && rd != 5'd0) regs[rd] = res;
      pc = pc + 32'd4;
      steps++;
    end
  endtask

  task automatic checkStore();
    assert (storeCnt < expAddr.size()) else begin
      $display("ERROR at %0t: store to %h beyond the %0d expected stores",
               $time, dcacheAddr, expAddr.size());
      errCnt++;
    end
    if (storeCnt < expAddr.size()) begin
      assert (dcacheAddr == expAddr[storeCnt]) else begin
        $display("FAILED %0t dcacheAddr_o expected %h actual %h",
                 $time, expAddr[storeCnt], dcacheAddr);
        errCnt++;
      end
      assert (dcacheWrData == expData[storeCnt]) else begin
        $display("FAILED %0t dcacheWrData_o expected %h actual %h",
                 $time, expData[storeCnt], dcacheWrData);
        errCnt++;
      end
    end
    storeCnt++;
  endtask

  // Both cache models and the random busy sources
  always @(posedge clk) begin
    logic coreEn;
    coreEn = !icacheBusy && !dcacheBusy; // Values the DUT sees at this edge
    cycleCnt <= cycleCnt + 1;
    if (coreEn && icacheEn) icacheData <= imem[icacheAddr[9:2]];
    if (coreEn && dcacheEn) begin
      if (dcacheWe) begin
        checkStore();
        dmem[dcacheAddr[7:2]] <= dcacheWrData;
      end else begin
        dcacheRdData <= dmem[dcacheAddr[7:2]];
      end
    end
    icacheBusy <= !rst && ($urandom_range(4, 0) == 0);
    dcacheBusy <= !rst && ($urandom_range(4, 0) == 0);
  end

  initial begin
    void'($urandom(Seed));
    rst          = 1'b1;
    icacheData   = '0;
    icacheBusy   = 1'b0;
    dcacheRdData = '0;
    dcacheBusy   = 1'b0;
    storeCnt     = 0;
    errCnt       = 0;
    cycleCnt     = 0;
    for (int k = 0; k < DataWords; k++) dmem[k] = fillWord(k);
    buildProgram();
    runModel();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (icacheAddr == 32'd0) else begin
      $display("FAILED %0t icacheAddr_o expected %h actual %h", $time, 32'd0, icacheAddr);
      errCnt++;
    end
    while (storeCnt < expAddr.size() && cycleCnt < TimeoutCycles) @(negedge clk);
    if (cycleCnt >= TimeoutCycles) begin
      $display("ERROR: run timed out after %0d cycles", cycleCnt);
      errCnt++;
    end else begin
      repeat (16) @(negedge clk); // Catch a store issued twice or late
    end
    $display("Stores checked: %0d of %0d, errors: %0d, assertion failures: %0d",
             storeCnt, expAddr.size(), errCnt, u_dut.u_asserts.failCnt);
    if (errCnt == 0 && u_dut.u_asserts.failCnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/coreTop_asserts.sv
`default_nettype none
`timescale 1ns/100ps

module coreTop_asserts (
  input logic        sys_clk_i,
  input logic        rst_i,
  input logic        icacheBusy_i,
  input logic        dcacheBusy_i,
  input logic [31:0] icacheAddr_o,
  input logic        icacheEn_o,
  input logic [31:0] dcacheAddr_o,
  input logic [31:0] dcacheWrData_o,
  input logic        dcacheWe_o,
  input logic        dcacheEn_o
);

  int failCnt = 0; // Number of failed assertions

  weWithEn: assert property (@(posedge sys_clk_i) disable iff (rst_i)
    dcacheWe_o |-> dcacheEn_o)
    else begin
      failCnt++;
      $error("dcacheWe_o high without dcacheEn_o");
    end

  // A stalled core must leave both ports untouched
  holdOnBusy: assert property (@(posedge sys_clk_i) disable iff (rst_i)
    (icacheBusy_i || dcacheBusy_i) |=> $stable({icacheAddr_o, icacheEn_o, dcacheAddr_o,
                                               dcacheWrData_o, dcacheWe_o, dcacheEn_o}))
    else begin
      failCnt++;
      $error("Port outputs changed during a busy stall");
    end

  wordAligned: assert property (@(posedge sys_clk_i) disable iff (rst_i)
    dcacheEn_o |-> (dcacheAddr_o[1:0] == 2'b00))
    else begin
      failCnt++;
      $error("dcacheAddr_o not word aligned");
    end

  resetValues: assert property (@(posedge sys_clk_i)
    rst_i |=> (icacheEn_o && !dcacheEn_o && !dcacheWe_o && icacheAddr_o == 32'd0))
    else begin
      failCnt++;
      $error("Port enables or fetch address wrong after reset");
    end

endmodule

bind coreTop coreTop_asserts u_asserts (
  .sys_clk_i      (sys_clk_i),
  .rst_i          (rst_i),
  .icacheBusy_i   (icacheBusy_i),
  .dcacheBusy_i   (dcacheBusy_i),
  .icacheAddr_o   (icacheAddr_o),
  .icacheEn_o     (icacheEn_o),
  .dcacheAddr_o   (dcacheAddr_o),
  .dcacheWrData_o (dcacheWrData_o),
  .dcacheWe_o     (dcacheWe_o),
  .dcacheEn_o     (dcacheEn_o)
);

`default_nettype wire
